/* logic/sq_accel_top.sv */
`timescale 1ns/1ps

module sq_accel_top #(
	parameter int OUT_DEPTH = 16
) (
	input  logic                      okClk,
	input  logic                      arst_n,
	input  logic                      op_en,
	input  logic                      in_valid,
	input  logic [sq_pkg::WORD_W-1:0] in_data,
	output logic                      in_ready,
	output logic                      out_valid,
	output logic [sq_pkg::WORD_W-1:0] out_data,
	input  logic                      out_ready,
	output logic                      op_done,
	output logic                      cmd_error
);
	import sq_pkg::*;

	logic              lb_valid;       // decode to result, loopback
	logic [WORD_W-1:0] lb_word;
	logic              lb_ready;
	logic              res_valid;      // execute to result
	result_word_t      res_word;
	logic              res_ready;

	sq_op_if op_bus ();

	sq_cmd_decode decode0 (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.op_en     (op_en),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.op        (op_bus.decode),
		.lb_valid  (lb_valid),
		.lb_word   (lb_word),
		.lb_ready  (lb_ready),
		.cmd_error (cmd_error)
	);

	sq_execute execute0 (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.op        (op_bus.execute),
		.res_valid (res_valid),
		.res_word  (res_word),
		.res_ready (res_ready)
	);

	sq_result #(
		.OUT_DEPTH (OUT_DEPTH)
	) result0 (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.res_valid (res_valid),
		.res_word  (res_word),
		.res_ready (res_ready),
		.lb_valid  (lb_valid),
		.lb_word   (lb_word),
		.lb_ready  (lb_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready),
		.op_done   (op_done)
	);

endmodule

/* logic/sq_cmd_decode.sv */
`timescale 1ns/1ps

module sq_cmd_decode (
	input  logic                      okClk,
	input  logic                      arst_n,
	input  logic                      op_en,
	input  logic                      in_valid,
	input  logic [sq_pkg::WORD_W-1:0] in_data,
	output logic                      in_ready,
	sq_op_if.decode                   op,
	output logic                      lb_valid,
	output logic [sq_pkg::WORD_W-1:0] lb_word,
	input  logic                      lb_ready,
	output logic                      cmd_error
);
	import sq_pkg::*;

	in_word_u           in_word;
	logic               in_acc;
	logic               ready_en;      // held low one cycle out of reset
	logic               open_q;        // header seen, data words pending
	logic               skip_q;        // illegal command, swallow its data
	logic [COUNT_W-1:0] cnt_q;         // data words left minus one
	logic               hdr_legal;
	logic               last_pend;     // last is out, busy not yet up

	assign in_word   = in_data;
	assign hdr_legal = (in_word.cmd.op_type <= OP_AVEPOOL);
	assign last_pend = op.dvalid && op.last;

	// lb_ready is low when the FIFO is full or a loopback word is stuck
	assign in_ready = ready_en && !op.busy && !last_pend && lb_ready;
	assign in_acc   = in_valid && in_ready;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			ready_en  <= 1'b0;
			open_q    <= 1'b0;
			skip_q    <= 1'b0;
			cnt_q     <= '0;
			lb_valid  <= 1'b0;
			op.start  <= 1'b0;
			op.dvalid <= 1'b0;
			op.last   <= 1'b0;
			cmd_error <= 1'b0;
		end else begin
			ready_en  <= 1'b1;
			op.start  <= 1'b0;                // strobes are single cycle
			op.dvalid <= 1'b0;
			op.last   <= 1'b0;
			if (lb_ready) begin
				lb_valid <= 1'b0;             // taken by result FIFO
			end
			if (in_acc) begin
				if (!open_q) begin
					if (!op_en) begin
						lb_valid <= 1'b1;     // loopback mode
					end else begin
						open_q   <= 1'b1;
						cnt_q    <= in_word.cmd.count_m1;
						skip_q   <= !hdr_legal;
						op.start <= hdr_legal;
						if (!hdr_legal) begin
							cmd_error <= 1'b1;   // sticky
						end
					end
				end else begin
					op.dvalid <= !skip_q;
					op.last   <= !skip_q && (cnt_q == '0);
					if (cnt_q == '0) begin
						open_q <= 1'b0;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
			end
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (in_acc && !open_q && !op_en) begin
			lb_word <= in_data;
		end
		if (in_acc && !open_q && op_en) begin
			op.op_type <= op_e'(in_word.cmd.op_type);
			op.shift   <= in_word.cmd.shift;
		end
		if (in_acc && open_q) begin
			op.data <= in_word.dat;
		end
	end

	// busy takes over from last_pend without a gap
	a_hold_while_busy: assert property (@(posedge okClk) disable iff (!arst_n)
		last_pend |=> op.busy)
		else $error("execute not busy after last word, input could pass a pending result");

endmodule

/* logic/sq_execute.sv */
`timescale 1ns/1ps

module sq_execute (
	input  logic                 okClk,
	input  logic                 arst_n,
	sq_op_if.execute             op,
	output logic                 res_valid,
	output sq_pkg::result_word_t res_word,
	input  logic                 res_ready
);
	import sq_pkg::*;

	localparam logic signed [ACC_W-1:0] SAT_MAX = 2**(SAMPLE_W-1) - 1;
	localparam logic signed [ACC_W-1:0] SAT_MIN = -(2**(SAMPLE_W-1));
	localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

	op_e                          op_q;
	logic [SHIFT_W-1:0]           shift_q;
	logic signed [ACC_W-1:0]      acc_q;
	logic signed [ACC_W-1:0]      acc_next;
	logic signed [ACC_W-1:0]      scaled;
	logic signed [SAMPLE_W-1:0]   hi;
	logic signed [SAMPLE_W-1:0]   lo;
	logic signed [2*SAMPLE_W-1:0] prod;
	logic signed [SAMPLE_W-1:0]   sat;
	logic                         busy_q;

	assign hi   = op.data.hi;
	assign lo   = op.data.lo;
	assign prod = hi * lo;

	// ------------------------------
	// reduction step
	// ------------------------------
	always_comb begin
		acc_next = acc_q;
		case (op_q)
			OP_CONV:    acc_next = acc_q + prod;     // mac
			OP_MAXPOOL: begin
				if (hi > acc_next) begin
					acc_next = hi;
				end
				if (lo > acc_next) begin
					acc_next = lo;
				end
			end
			OP_AVEPOOL: acc_next = acc_q + hi + lo;
			default:    acc_next = acc_q;
		endcase
	end

	// final value is taken straight from acc_next on the last word
	assign scaled = (op_q == OP_MAXPOOL) ? acc_next : (acc_next >>> shift_q);

	always_comb begin
		if (scaled > SAT_MAX) begin
			sat = SAT_MAX[SAMPLE_W-1:0];
		end else if (scaled < SAT_MIN) begin
			sat = SAT_MIN[SAMPLE_W-1:0];
		end else begin
			sat = scaled[SAMPLE_W-1:0];
		end
	end

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
		end else if (op.dvalid && op.last) begin
			busy_q <= 1'b1;                      // result ready next cycle
		end else if (busy_q && res_ready) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge okClk) begin
		if (op.start) begin
			op_q    <= op.op_type;
			shift_q <= op.shift;
			acc_q   <= (op.op_type == OP_MAXPOOL) ? ACC_MIN : '0;
		end else if (op.dvalid) begin
			acc_q <= acc_next;
		end
		if (op.dvalid && op.last) begin
			res_word.op_type <= op_q;
			res_word.zero    <= '0;
			res_word.value   <= sat;
		end
	end

	assign res_valid = busy_q;
	assign op.busy   = busy_q;

	a_no_data_busy: assert property (@(posedge okClk) disable iff (!arst_n)
		(op.start || op.dvalid) |-> !busy_q)
		else $error("operation strobe while result pending");

endmodule

/* logic/sq_op_if.sv */
`timescale 1ns/1ps

interface sq_op_if;
	import sq_pkg::*;

	// ------------------------------
	// operation setup
	// ------------------------------
	logic               start;      // one cycle, new operation
	op_e                op_type;    // valid with start
	logic [SHIFT_W-1:0] shift;      // valid with start

	// ------------------------------
	// data stream
	// ------------------------------
	logic               dvalid;     // one data word
	data_word_t         data;
	logic               last;       // final word of operation

	// high from the cycle after last until the result is taken
	logic               busy;

	modport decode (
		output start,
		output op_type,
		output shift,
		output dvalid,
		output data,
		output last,
		input  busy
	);

	modport execute (
		input  start,
		input  op_type,
		input  shift,
		input  dvalid,
		input  data,
		input  last,
		output busy
	);

endinterface

/* logic/sq_pkg.sv */
package sq_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int WORD_W   = 32;    // host stream word
	localparam int SAMPLE_W = 16;    // fixed-point sample
	localparam int ACC_W    = 40;    // room for 256 full-scale products
	localparam int COUNT_W  = 8;
	localparam int SHIFT_W  = 5;

	// ------------------------------
	// op codes and word layouts
	// ------------------------------
	typedef enum logic [2:0] {
		OP_CONV    = 3'd0,
		OP_MAXPOOL = 3'd1,
		OP_AVEPOOL = 3'd2
	} op_e;                          // 3..7 rejected by decode

	typedef struct packed {
		logic [2:0]         op_type;     // raw, may be illegal
		logic [SHIFT_W-1:0] shift;       // output scaling
		logic [15:0]        reserved;
		logic [COUNT_W-1:0] count_m1;    // data words minus one
	} cmd_hdr_t;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] hi;  // sample
		logic signed [SAMPLE_W-1:0] lo;  // weight for conv
	} data_word_t;

	// Same 32 bits, read as header or as data depending on decoder state.
	typedef union packed {
		cmd_hdr_t   cmd;
		data_word_t dat;
	} in_word_u;

	typedef struct packed {
		op_e                        op_type;
		logic [12:0]                zero;
		logic signed [SAMPLE_W-1:0] value;   // saturated result
	} result_word_t;

endpackage

/* logic/sq_result.sv */
`timescale 1ns/1ps

module sq_result #(
	parameter int OUT_DEPTH = 16
) (
	input  logic                      okClk,
	input  logic                      arst_n,
	input  logic                      res_valid,
	input  sq_pkg::result_word_t      res_word,
	output logic                      res_ready,
	input  logic                      lb_valid,
	input  logic [sq_pkg::WORD_W-1:0] lb_word,
	output logic                      lb_ready,
	output logic                      out_valid,
	output logic [sq_pkg::WORD_W-1:0] out_data,
	input  logic                      out_ready,
	output logic                      op_done
);
	import sq_pkg::*;

	localparam int AW = $clog2(OUT_DEPTH);

	logic [WORD_W-1:0] mem [OUT_DEPTH];
	logic [AW:0]       wr_ptr;             // extra bit tells full from empty
	logic [AW:0]       rd_ptr;
	logic              full;
	logic              empty;
	logic              res_acc;
	logic              lb_acc;
	logic              wr_en;
	logic              rd_en;
	logic [WORD_W-1:0] wr_data;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// ------------------------------
	// write side arbitration
	// ------------------------------
	assign res_ready = !full;
	assign lb_ready  = !full && !res_valid;    // result wins
	assign res_acc   = res_valid && res_ready;
	assign lb_acc    = lb_valid && lb_ready;
	assign wr_en     = res_acc || lb_acc;
	assign wr_data   = res_valid ? res_word : lb_word;

	// first word fall through
	assign out_valid = !empty;
	assign out_data  = mem[rd_ptr[AW-1:0]];
	assign rd_en     = out_valid && out_ready;

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			op_done <= 1'b0;
		end else begin
			op_done <= res_acc;                // one pulse per result
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	// occupancy from the pointers never exceeds the depth
	a_no_write_full: assert property (@(posedge okClk) disable iff (!arst_n)
		(AW+1)'(wr_ptr - rd_ptr) <= OUT_DEPTH)
		else $error("output FIFO holds more words than its depth");

	a_no_read_empty: assert property (@(posedge okClk) disable iff (!arst_n)
		empty |=> (rd_ptr == $past(rd_ptr)))
		else $error("output FIFO read while empty");

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sq_accel \
	-f src.f

./obj_dir/Vtb_sq_accel > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* src.f */
logic/sq_pkg.sv
logic/sq_op_if.sv
logic/sq_cmd_decode.sv
logic/sq_execute.sv
logic/sq_result.sv
logic/sq_accel_top.sv
verification/tb_clkgen.sv
verification/tb_sq_accel.sv

/* verification/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
	output logic okClk,
	output logic arst_n
);

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;      // 10 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge okClk);
		#1 arst_n = 1'b1;               // release just after the 5th edge
	end

endmodule

/* verification/tb_sq_accel.sv */
`timescale 1ns/1ps

module tb_sq_accel;
	import sq_pkg::*;

	logic        okClk;
	logic        arst_n;
	logic        op_en;
	logic        in_valid;
	logic [31:0] in_data;
	logic        in_ready;
	logic        out_valid;
	logic [31:0] out_data;
	logic        out_ready;
	logic        op_done;
	logic        cmd_error;

	integer      seed = 32'h6e0143da;
	logic [31:0] stim_word [$];        // pending input words
	bit          stim_en [$];          // op_en level for each word
	int          stim_gap [$];         // idle cycles before each word
	logic [31:0] exp_q [$];            // expected output words
	int          errors = 0;
	int          compared = 0;
	int          done_pulses = 0;
	int          legal_cmds = 0;
	int          bp_cycles = 0;
	int          cycle = 0;
	int          cycle_limit = 1000;
	int          stall_req = 0;

	tb_clkgen clkgen0 (.okClk(okClk), .arst_n(arst_n));

	sq_accel_top #(.OUT_DEPTH(16)) dut0 (
		.okClk(okClk), .arst_n(arst_n), .op_en(op_en),
		.in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
		.out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
		.op_done(op_done), .cmd_error(cmd_error)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	function logic [15:0] sat16(input longint v);
		if (v > 32767) return 16'h7fff;
		if (v < -32768) return 16'h8000;
		return v[15:0];
	endfunction

	function logic [15:0] rand_sample(input bit big);
		logic [31:0] r;
		r = $random(seed);
		if (big && r[31:30] == 2'd0) return 16'h7fff;   // full scale to hit saturation
		if (big && r[31:30] == 2'd1) return 16'h8000;
		return r[15:0];
	endfunction

	task queue_word(input bit en, input logic [31:0] w);
		logic [31:0] r;
		r = $random(seed);
		stim_word.push_back(w);
		stim_en.push_back(en);
		stim_gap.push_back((r[2:0] == 3'd0) ? 1 + r[4:3] : 0);
		cycle_limit += 20;
	endtask

	task queue_loopback();
		logic [31:0] w;
		w = $random(seed);
		queue_word(1'b0, w);
		exp_q.push_back(w);              // passes unchanged
	endtask

	task queue_cmd(input logic [2:0] op, input logic [4:0] sh, input logic [7:0] cm1,
		input bit big);
		logic [31:0] r;
		logic [15:0] h;
		logic [15:0] l;
		longint      acc;
		r = $random(seed);
		queue_word(1'b1, {op, sh, r[15:0], cm1});    // reserved bits random
		acc = (op == OP_MAXPOOL) ? -(longint'(1) <<< 39) : 0;
		for (int i = 0; i <= cm1; i++) begin
			h = rand_sample(big);
			l = rand_sample(big);
			queue_word(1'b1, {h, l});
			case (op)
				OP_CONV:    acc = acc + longint'($signed(h)) * longint'($signed(l));
				OP_MAXPOOL: begin
					if (longint'($signed(h)) > acc) begin
						acc = longint'($signed(h));
					end
					if (longint'($signed(l)) > acc) begin
						acc = longint'($signed(l));
					end
				end
				OP_AVEPOOL: acc = acc + longint'($signed(h)) + longint'($signed(l));
				default:    acc = acc;           // illegal, data only skipped
			endcase
		end
		if (op <= OP_AVEPOOL) begin
			if (op != OP_MAXPOOL) begin
				acc = acc >>> sh;
			end
			exp_q.push_back({op, 13'h0, sat16(acc)});
			legal_cmds++;
		end
	endtask

	// ------------------------------
	// drivers
	// ------------------------------
	task drive_word(input bit en, input logic [31:0] w, input int gap);
		in_valid = 1'b0;
		repeat (gap) begin
			@(posedge okClk);
			#1;
		end
		op_en    = en;
		in_data  = w;
		in_valid = 1'b1;
		@(posedge okClk);
		while (!in_ready) @(posedge okClk);
		#1;
	endtask

	task run_stim();
		while (stim_word.size() > 0) begin
			drive_word(stim_en.pop_front(), stim_word.pop_front(), stim_gap.pop_front());
		end
		in_valid = 1'b0;
	endtask

	task wait_drain();
		while (exp_q.size() > 0) begin
			@(posedge okClk);
			#1;
		end
	endtask

	// out_ready about 70 % high, with a long low stretch on request
	initial begin
		logic [31:0] r;
		int          stall_ack;
		int          stall_left;
		out_ready  = 1'b0;
		stall_ack  = 0;
		stall_left = 0;
		forever begin
			@(posedge okClk);
			if (stall_req != stall_ack) begin
				stall_ack  = stall_req;
				stall_left = 60;
			end
			r = $random(seed);
			#1;
			if (stall_left > 0) begin
				out_ready = 1'b0;
				stall_left--;
			end else begin
				out_ready = (r[9:0] < 10'd717);
			end
		end
	end

	// ------------------------------
	// output checker and timeout
	// ------------------------------
	always @(posedge okClk) begin : out_check
		logic [31:0] exp_word;
		if (arst_n) begin
			cycle++;
			if (op_done) begin
				done_pulses++;
			end
			if (in_valid && !in_ready) begin
				bp_cycles++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("output word %08h arrived with no word expected", out_data);
					errors++;
				end else begin
					exp_word = exp_q.pop_front();
					compared++;
					if (out_data !== exp_word) begin
						$display("Mismatch out_data: expected %08h, actual %08h", exp_word, out_data);
						errors++;
					end
				end
			end
			if (cycle > cycle_limit) begin
				$display("timeout after %0d cycles, %0d output words never arrived",
					cycle_limit, exp_q.size());
				$display("TEST RESULT: FAIL");
				$finish;
			end
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		logic [31:0] r;
		op_en    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		@(posedge arst_n);
		if (in_ready !== 1'b0 || out_valid !== 1'b0 || op_done !== 1'b0 || cmd_error !== 1'b0) begin
			$display("outputs not idle right after reset release");
			errors++;
		end
		@(posedge okClk);
		#1;

		stall_req++;                       // hold output long enough to fill the FIFO
		repeat (24) queue_loopback();
		run_stim();
		if (bp_cycles == 0) begin
			$display("input never back-pressured while output was stalled");
			errors++;
		end
		repeat (20) queue_loopback();
		run_stim();

		repeat (8) begin
			r = $random(seed);
			queue_cmd(OP_CONV, r[4:0], {4'h0, r[11:8]}, r[16]);
		end
		queue_cmd(OP_CONV, 5'd2, 8'd255, 1'b1);   // long run, saturates
		run_stim();

		repeat (6) begin
			r = $random(seed);
			queue_cmd(OP_MAXPOOL, r[4:0], {4'h0, r[11:8]}, r[16]);
			r = $random(seed);
			queue_cmd(OP_AVEPOOL, {2'b00, r[2:0]}, {4'h0, r[11:8]}, r[16]);
		end
		run_stim();

		wait_drain();
		if (cmd_error !== 1'b0) begin
			$display("Mismatch cmd_error: expected 0, actual %0h", cmd_error);
			errors++;
		end
		repeat (3) begin
			r = $random(seed);
			queue_cmd((r[2:0] < 3'd3) ? r[2:0] + 3'd3 : r[2:0], r[12:8], {5'h0, r[18:16]}, 1'b0);
			queue_cmd(OP_CONV, r[24:20], {5'h0, r[27:25]}, r[28]);
		end
		run_stim();
		wait_drain();
		if (cmd_error !== 1'b1) begin
			$display("Mismatch cmd_error: expected 1, actual %0h", cmd_error);
			errors++;
		end

		repeat (40) begin                   // op_en toggles between operations
			r = $random(seed);
			if (r[1:0] == 2'd0) begin
				queue_cmd(r[9:8] % 3, r[14:10], {4'h0, r[19:16]}, r[20]);
			end else begin
				queue_loopback();
			end
		end
		run_stim();
		wait_drain();
		repeat (5) @(posedge okClk);
		#1;
		if (done_pulses != legal_cmds) begin
			$display("Mismatch op_done count: expected %0h, actual %0h", legal_cmds, done_pulses);
			errors++;
		end

		$display("errors: %0d, words compared: %0d, op_done pulses: %0d",
			errors, compared, done_pulses);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
